// File: src.f
+incdir+.
pipeTypesPkg.sv
memBusPkg.sv
pipeStageReg.sv
memAccessUnit.sv
dataRam.sv
memStage.sv
tb_memStage.sv

// File: run.sh
#!/bin/sh
# build and run the memStage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_memStage \
    -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// File: tb_memStage.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_memStage
    import pipeTypesPkg::*;
    import memBusPkg::*;
();

    localparam int WaitLimit = 100;
    localparam int ByteAddrW = `RAM_ADDR_W + 2;

    logic                   clk;
    logic                   rst;
    logic                   flush;
    logic                   exeValid;
    logic [`DATA_WIDTH-1:0] exePc;
    logic [`DATA_WIDTH-1:0] exeAluOut;
    logic [`DATA_WIDTH-1:0] exeStoreData;
    LoadType                exeLoadType;
    StoreType               exeStoreType;
    logic [4:0]             exeDst;
    logic                   exeRegWrite;
    WbSelType               exeWbSel;
    logic                   exeReady;
    logic                   wbValid;
    logic [`DATA_WIDTH-1:0] wbPc;
    logic [4:0]             wbDst;
    logic                   wbRegWrite;
    logic [`DATA_WIDTH-1:0] wbData;
    ExcCode                 wbExc;

    // byte-wide little-endian model of the data RAM
    logic [7:0]             refMem [4*`RAM_WORDS] = '{default: '0};
    MemWbPayload            expQ[$];
    MemWbPayload            expNow;
    logic                   expMissing;
    logic                   issueAccess;
    logic                   prevAccept;
    logic [`DATA_WIDTH-1:0] pcNext;
    int                     errCount;
    int                     errAtStart;
    int                     testsRun;
    int                     testsFailed;

    memStage u_dut (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .exeValid     (exeValid),
        .exePc        (exePc),
        .exeAluOut    (exeAluOut),
        .exeStoreData (exeStoreData),
        .exeLoadType  (exeLoadType),
        .exeStoreType (exeStoreType),
        .exeDst       (exeDst),
        .exeRegWrite  (exeRegWrite),
        .exeWbSel     (exeWbSel),
        .exeReady     (exeReady),
        .wbValid      (wbValid),
        .wbPc         (wbPc),
        .wbDst        (wbDst),
        .wbRegWrite   (wbRegWrite),
        .wbData       (wbData),
        .wbExc        (wbExc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // natural alignment rule for halfwords and words
    function automatic ExcCode excFor(input LoadType ld, input StoreType st,
                                      input logic [31:0] a);
        ExcCode e;
        e = ExcNone;
        if ((ld == LdLh || ld == LdLhu) && a[0]) e = ExcLoadMisalign;
        if (ld == LdLw && a[1:0] != 2'b00) e = ExcLoadMisalign;
        if (st == StSh && a[0]) e = ExcStoreMisalign;
        if (st == StSw && a[1:0] != 2'b00) e = ExcStoreMisalign;
        return e;
    endfunction

    function automatic logic [31:0] loadValue(input LoadType ld, input logic [ByteAddrW-1:0] a);
        logic [ByteAddrW-1:0] a1;
        logic [ByteAddrW-1:0] a2;
        logic [ByteAddrW-1:0] a3;
        logic [31:0]          v;
        a1 = a + ByteAddrW'(1);
        a2 = a + ByteAddrW'(2);
        a3 = a + ByteAddrW'(3);
        case (ld)
            LdLb:    v = {{24{refMem[a][7]}}, refMem[a]};
            LdLbu:   v = {24'h0, refMem[a]};
            LdLh:    v = {{16{refMem[a1][7]}}, refMem[a1], refMem[a]};
            LdLhu:   v = {16'h0, refMem[a1], refMem[a]};
            default: v = {refMem[a3], refMem[a2], refMem[a1], refMem[a]};
        endcase
        return v;
    endfunction

    task automatic storeModel(input StoreType st, input logic [ByteAddrW-1:0] a,
                              input logic [31:0] d);
        logic [ByteAddrW-1:0] a1;
        a1 = a + ByteAddrW'(1);
        refMem[a] = d[7:0];
        if (st != StSb) refMem[a1] = d[15:8];
        if (st == StSw) begin
            refMem[a + ByteAddrW'(2)] = d[23:16];
            refMem[a + ByteAddrW'(3)] = d[31:24];
        end
    endtask

    task automatic reportValue(input string name, input logic [31:0] got, input logic [31:0] want);
        errCount++;
        $display("[FAIL] %s got %h expected %h", name, got, want);
    endtask

    // runs from a falling edge to the falling edge after acceptance
    task automatic issue(input LoadType ld, input StoreType st, input WbSelType sel,
                         input logic [31:0] addr, input logic [31:0] sdata,
                         input logic rw, input bit expectWb);
        MemWbPayload rec;
        ExcCode      exc;
        int          waited;
        exc          = excFor(ld, st, addr);
        exeValid     = 1'b1;
        exePc        = pcNext;
        exeAluOut    = addr;
        exeStoreData = sdata;
        exeLoadType  = ld;
        exeStoreType = st;
        exeDst       = 5'($urandom);
        exeRegWrite  = rw;
        exeWbSel     = sel;
        waited       = 0;
        while (!exeReady && waited < WaitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (!exeReady) begin
            errCount++;
            $display("exeReady stayed low, instruction at pc %h was never accepted", pcNext);
        end else begin
            rec.valid    = 1'b1;
            rec.pc       = pcNext;
            rec.dst      = exeDst;
            rec.regWrite = rw && exc == ExcNone;
            rec.exc      = exc;
            case (sel)
                WbMem:   rec.wbData = loadValue(ld, addr[ByteAddrW-1:0]);
                WbLink:  rec.wbData = pcNext + 32'd8;
                default: rec.wbData = addr;
            endcase
            if (st != StNone && exc == ExcNone) storeModel(st, addr[ByteAddrW-1:0], sdata);
            if (expectWb) expQ.push_back(rec);
        end
        @(negedge clk);
        exeValid = 1'b0;
        pcNext   = pcNext + 32'd4;
    endtask

    task automatic alu(input logic [31:0] value, input bit expectWb);
        issue(LdNone, StNone, WbAlu, value, 32'h0, 1'b1, expectWb);
    endtask

    task automatic link();
        issue(LdNone, StNone, WbLink, $urandom, 32'h0, 1'b1, 1'b1);
    endtask

    task automatic store(input StoreType st, input logic [31:0] a, input bit expectWb);
        issue(LdNone, st, WbAlu, a, $urandom, 1'b0, expectWb);
    endtask

    task automatic load(input LoadType ld, input logic [31:0] a);
        issue(ld, StNone, WbMem, a, 32'h0, 1'b1, 1'b1);
    endtask

    task automatic flushNow();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    // flush only once the RAM request is out
    task automatic flushDuringAccess();
        int waited;
        waited = 0;
        while (!u_dut.memReq && waited < WaitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (!u_dut.memReq) begin
            errCount++;
            $display("no memory request seen for the store that should be flushed");
        end
        flushNow();
    endtask

    task automatic endTest(input string name);
        int waited;
        waited = 0;
        while ((expQ.size() != 0 || !exeReady) && waited < WaitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (expQ.size() != 0 || !exeReady) begin
            errCount++;
            $display("timed out with %0d writebacks still missing", expQ.size());
            expQ.delete();
        end
        repeat (2) @(negedge clk);
        testsRun++;
        if (errCount != errAtStart) testsFailed++;
        $display("test %-24s %s", name, (errCount == errAtStart) ? "ok" : "failed");
        errAtStart = errCount;
    endtask

    // pick up the record for the writeback now on the outputs
    always @(negedge clk) begin
        expMissing = 1'b0;
        if (wbValid) begin
            if (expQ.size() == 0) expMissing = 1'b1;
            else expNow = expQ.pop_front();
        end
    end

    assign issueAccess = (exeLoadType != LdNone || exeStoreType != StNone)
                         && excFor(exeLoadType, exeStoreType, exeAluOut) == ExcNone;

    always @(posedge clk) begin
        prevAccept <= !rst && exeValid && exeReady && !flush && !issueAccess;
    end

    resetClean: assert property (@(posedge clk) rst |=> !wbValid && exeReady)
        else begin
            errCount++;
            $display("wbValid or exeReady wrong after reset");
        end

    wbExpected: assert property (@(posedge clk) disable iff (rst) wbValid |-> !expMissing)
        else begin
            errCount++;
            $display("writeback at pc %h appeared with none expected", $sampled(wbPc));
        end

    pcCheck: assert property (@(posedge clk) disable iff (rst)
        wbValid && !expMissing |-> wbPc == expNow.pc)
        else reportValue("wbPc", $sampled(wbPc), expNow.pc);

    dstCheck: assert property (@(posedge clk) disable iff (rst)
        wbValid && !expMissing |-> wbDst == expNow.dst)
        else reportValue("wbDst", 32'($sampled(wbDst)), 32'(expNow.dst));

    regWriteCheck: assert property (@(posedge clk) disable iff (rst)
        wbValid && !expMissing |-> wbRegWrite == expNow.regWrite)
        else reportValue("wbRegWrite", 32'($sampled(wbRegWrite)), 32'(expNow.regWrite));

    excCheck: assert property (@(posedge clk) disable iff (rst)
        wbValid && !expMissing |-> wbExc == expNow.exc)
        else reportValue("wbExc", 32'($sampled(wbExc)), 32'(expNow.exc));

    dataCheck: assert property (@(posedge clk) disable iff (rst)
        wbValid && !expMissing && expNow.exc == ExcNone |-> wbData == expNow.wbData)
        else reportValue("wbData", $sampled(wbData), expNow.wbData);

    // non-access instructions leave MEM one cycle after acceptance
    oneCycleWb: assert property (@(posedge clk) disable iff (rst)
        prevAccept && !flush |=> wbValid)
        else begin
            errCount++;
            $display("writeback missing one cycle after acceptance");
        end

    accessStalls: assert property (@(posedge clk) disable iff (rst)
        exeValid && exeReady && !flush && issueAccess |=> !exeReady)
        else begin
            errCount++;
            $display("exeReady stayed high while a memory access started");
        end

    initial begin
        void'($urandom(94));
        rst          = 1'b1;
        flush        = 1'b0;
        exeValid     = 1'b0;
        exePc        = '0;
        exeAluOut    = '0;
        exeStoreData = '0;
        exeLoadType  = LdNone;
        exeStoreType = StNone;
        exeDst       = '0;
        exeRegWrite  = 1'b0;
        exeWbSel     = WbAlu;
        pcNext       = 32'h400;
        errCount     = 0;
        errAtStart   = 0;
        testsRun     = 0;
        testsFailed  = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        repeat (4) alu($urandom, 1'b1);
        link();
        alu($urandom, 1'b1);
        endTest("alu back to back");

        store(StSw, 32'h40, 1'b1);
        load(LdLw, 32'h40);
        alu($urandom, 1'b1);
        store(StSw, 32'h44, 1'b1);
        load(LdLw, 32'h44);
        endTest("store then load word");

        for (int off = 0; off < 4; off++) begin
            store(StSb, 32'h80 + off, 1'b1);
            load(LdLb, 32'h80 + off);
            load(LdLbu, 32'h80 + off);
        end
        for (int off = 0; off < 4; off += 2) begin
            store(StSh, 32'h84 + off, 1'b1);
            load(LdLh, 32'h84 + off);
            load(LdLhu, 32'h84 + off);
        end
        store(StSw, 32'h88, 1'b1);
        store(StSb, 32'h89, 1'b1);
        store(StSh, 32'h8a, 1'b1);
        load(LdLb, 32'h85);
        load(LdLw, 32'h80);
        load(LdLw, 32'h84);
        load(LdLw, 32'h88);
        endTest("byte and halfword lanes");

        store(StSw, 32'h90, 1'b1);
        load(LdLh, 32'h91);
        load(LdLhu, 32'h93);
        load(LdLw, 32'h92);
        store(StSh, 32'h91, 1'b1);
        store(StSw, 32'h93, 1'b1);
        load(LdLw, 32'h90);
        load(LdLw, 32'h94);
        endTest("misaligned access");

        alu($urandom, 1'b1);
        alu($urandom, 1'b0);
        flushNow();
        alu($urandom, 1'b1);
        store(StSw, 32'hc0, 1'b0);
        flushDuringAccess();
        load(LdLw, 32'hc0);
        endTest("flush");

        $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: memStage.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module memStage
    import pipeTypesPkg::*;
    import memBusPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   exeValid,
    input  logic [`DATA_WIDTH-1:0] exePc,
    input  logic [`DATA_WIDTH-1:0] exeAluOut,
    input  logic [`DATA_WIDTH-1:0] exeStoreData,
    input  LoadType                exeLoadType,
    input  StoreType               exeStoreType,
    input  logic [4:0]             exeDst,
    input  logic                   exeRegWrite,
    input  WbSelType               exeWbSel,
    output logic                   exeReady,
    output logic                   wbValid,
    output logic [`DATA_WIDTH-1:0] wbPc,
    output logic [4:0]             wbDst,
    output logic                   wbRegWrite,
    output logic [`DATA_WIDTH-1:0] wbData,
    output ExcCode                 wbExc
);

    ExeMemPayload           exeMemIn;
    ExeMemPayload           memIn;
    MemWbPayload            memWbIn;
    MemWbPayload            memWbOut;
    logic                   stageAdvance;
    logic                   wbFlush;
    logic                   memReq;
    logic                   memWe;
    logic [`RAM_ADDR_W-1:0] memAddr;
    ByteEnable              memBe;
    logic [`DATA_WIDTH-1:0] memWdata;
    logic                   memAck;
    logic [`DATA_WIDTH-1:0] memRdata;

    // execute side into the EXE/MEM payload
    assign exeMemIn.valid     = exeValid;
    assign exeMemIn.pc        = exePc;
    assign exeMemIn.aluOut    = exeAluOut;
    assign exeMemIn.storeData = exeStoreData;
    assign exeMemIn.loadType  = exeLoadType;
    assign exeMemIn.storeType = exeStoreType;
    assign exeMemIn.dst       = exeDst;
    assign exeMemIn.regWrite  = exeRegWrite;
    assign exeMemIn.wbSel     = exeWbSel;

    assign exeReady = stageAdvance;

    pipeStageReg #(.PayloadT(ExeMemPayload)) u_exeMem (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .wr      (stageAdvance),
        .inData  (exeMemIn),
        .outData (memIn)
    );

    memAccessUnit u_access (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .memIn        (memIn),
        .memAck       (memAck),
        .memRdata     (memRdata),
        .stageAdvance (stageAdvance),
        .wbFlush      (wbFlush),
        .wbOut        (memWbIn),
        .memReq       (memReq),
        .memWe        (memWe),
        .memAddr      (memAddr),
        .memBe        (memBe),
        .memWdata     (memWdata)
    );

    dataRam u_ram (
        .clk      (clk),
        .rst      (rst),
        .memReq   (memReq),
        .memWe    (memWe),
        .memAddr  (memAddr),
        .memBe    (memBe),
        .memWdata (memWdata),
        .memAck   (memAck),
        .memRdata (memRdata)
    );

    // bubble enters MEM/WB through wbFlush while MEM stalls
    pipeStageReg #(.PayloadT(MemWbPayload)) u_memWb (
        .clk     (clk),
        .rst     (rst),
        .flush   (wbFlush),
        .wr      (stageAdvance),
        .inData  (memWbIn),
        .outData (memWbOut)
    );

    assign wbValid    = memWbOut.valid;
    assign wbPc       = memWbOut.pc;
    assign wbDst      = memWbOut.dst;
    assign wbRegWrite = memWbOut.regWrite;
    assign wbData     = memWbOut.wbData;
    assign wbExc      = memWbOut.exc;

endmodule

// File: dataRam.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module dataRam
    import memBusPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   memReq,
    input  logic                   memWe,
    input  logic [`RAM_ADDR_W-1:0] memAddr,
    input  ByteEnable              memBe,
    input  logic [`DATA_WIDTH-1:0] memWdata,
    output logic                   memAck,
    output logic [`DATA_WIDTH-1:0] memRdata
);

    localparam int CntW = $clog2(`ACK_DELAY + 1);

    logic [`DATA_WIDTH-1:0] mem [`RAM_WORDS] = '{default: '0};
    logic [CntW-1:0]        delayCnt;
    logic                   ackDue;

    // last wait cycle of a pending request
    assign ackDue = memReq && !memAck && (delayCnt == CntW'(`ACK_DELAY - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            memAck   <= 1'b0;
            delayCnt <= '0;
        end else if (!memReq) begin
            memAck   <= 1'b0;
            delayCnt <= '0;
        end else if (ackDue) begin
            memAck <= 1'b1;
        end else if (!memAck) begin
            delayCnt <= delayCnt + 1'b1;
        end
    end

    // one access per handshake, taken on the edge that raises ack
    always_ff @(posedge clk) begin
        if (ackDue) begin
            if (memWe) begin
                for (int b = 0; b < `DATA_WIDTH / 8; b++) begin
                    if (memBe[b]) begin
                        mem[memAddr][8*b +: 8] <= memWdata[8*b +: 8];
                    end
                end
            end
            memRdata <= mem[memAddr];
        end
    end

    // master must wait for ack to drop before the next request
    reqRiseAckLow: assert property (@(posedge clk) disable iff (rst)
        $rose(memReq) |-> !memAck);

endmodule

// File: memAccessUnit.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module memAccessUnit
    import pipeTypesPkg::*;
    import memBusPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  ExeMemPayload           memIn,
    input  logic                   memAck,
    input  logic [`DATA_WIDTH-1:0] memRdata,
    output logic                   stageAdvance,
    output logic                   wbFlush,
    output MemWbPayload            wbOut,
    output logic                   memReq,
    output logic                   memWe,
    output logic [`RAM_ADDR_W-1:0] memAddr,
    output ByteEnable              memBe,
    output logic [`DATA_WIDTH-1:0] memWdata
);

    typedef enum logic {
        Idle,
        WaitAck
    } AccessState;

    AccessState             state;
    ByteLane                lane;
    logic                   isLoad;
    logic                   isStore;
    logic                   loadMisaligned;
    logic                   storeMisaligned;
    logic                   needAccess;
    logic                   accessDone;
    logic                   discarded;
    ByteEnable              storeBe;
    logic [`DATA_WIDTH-1:0] storeWord;
    logic [`DATA_WIDTH-1:0] loadWord;
    logic [`DATA_WIDTH-1:0] loadData;
    logic [7:0]             loadByte;
    logic [15:0]            loadHalf;

    assign lane    = ByteLane'(memIn.aluOut[1:0]);
    assign isLoad  = memIn.loadType != LdNone;
    assign isStore = memIn.storeType != StNone;

    // natural alignment
    always_comb begin
        loadMisaligned  = 1'b0;
        storeMisaligned = 1'b0;
        case (memIn.loadType)
            LdLh, LdLhu: loadMisaligned = memIn.aluOut[0];
            LdLw:        loadMisaligned = |memIn.aluOut[1:0];
            default:     loadMisaligned = 1'b0;
        endcase
        case (memIn.storeType)
            StSh:    storeMisaligned = memIn.aluOut[0];
            StSw:    storeMisaligned = |memIn.aluOut[1:0];
            default: storeMisaligned = 1'b0;
        endcase
    end

    assign needAccess = memIn.valid && (isLoad || isStore) && !loadMisaligned
                        && !storeMisaligned;

    // ack has been seen high and has dropped again
    assign accessDone = (state == WaitAck) && !memReq && !memAck;

    assign stageAdvance = (state == Idle) ? !needAccess : accessDone;
    assign wbFlush      = flush || !stageAdvance || discarded;

    // replicate store data over the lanes
    always_comb begin
        storeBe   = 4'b0000;
        storeWord = memIn.storeData;
        case (memIn.storeType)
            StSb: begin
                storeBe   = laneMask(lane);
                storeWord = {(`DATA_WIDTH / 8){memIn.storeData[7:0]}};
            end
            StSh: begin
                storeBe   = memIn.aluOut[1] ? 4'b1100 : 4'b0011;
                storeWord = {(`DATA_WIDTH / 16){memIn.storeData[15:0]}};
            end
            StSw:    storeBe = 4'b1111;
            default: storeBe = 4'b0000;
        endcase
    end

    // handshake control
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= Idle;
            memReq    <= 1'b0;
            discarded <= 1'b0;
        end else begin
            case (state)
                Idle: begin
                    if (needAccess && !flush) begin
                        state  <= WaitAck;
                        memReq <= 1'b1;
                    end
                end
                WaitAck: begin
                    if (memReq && memAck) begin
                        memReq <= 1'b0;
                    end
                    // the handshake still runs to completion
                    if (flush) begin
                        discarded <= 1'b1;
                    end
                    if (accessDone) begin
                        state     <= Idle;
                        discarded <= 1'b0;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    // request fields held for the whole handshake
    always_ff @(posedge clk) begin
        if (state == Idle && needAccess) begin
            memWe    <= isStore;
            memAddr  <= memIn.aluOut[`RAM_ADDR_W+1:2];
            memBe    <= isStore ? storeBe : 4'b1111;
            memWdata <= storeWord;
        end
        if (memReq && memAck) begin
            loadWord <= memRdata;
        end
    end

    // lane select then extend
    always_comb begin
        case (lane)
            Lane0:   loadByte = loadWord[7:0];
            Lane1:   loadByte = loadWord[15:8];
            Lane2:   loadByte = loadWord[23:16];
            default: loadByte = loadWord[31:24];
        endcase
        loadHalf = memIn.aluOut[1] ? loadWord[31:16] : loadWord[15:0];
        case (memIn.loadType)
            LdLb:    loadData = {{(`DATA_WIDTH - 8){loadByte[7]}}, loadByte};
            LdLbu:   loadData = {{(`DATA_WIDTH - 8){1'b0}}, loadByte};
            LdLh:    loadData = {{(`DATA_WIDTH - 16){loadHalf[15]}}, loadHalf};
            LdLhu:   loadData = {{(`DATA_WIDTH - 16){1'b0}}, loadHalf};
            default: loadData = loadWord;
        endcase
    end

    always_comb begin
        wbOut.valid    = memIn.valid;
        wbOut.pc       = memIn.pc;
        wbOut.dst      = memIn.dst;
        // a faulting access never writes the register file
        wbOut.regWrite = memIn.regWrite && !loadMisaligned && !storeMisaligned;
        if (loadMisaligned) begin
            wbOut.exc = ExcLoadMisalign;
        end else if (storeMisaligned) begin
            wbOut.exc = ExcStoreMisalign;
        end else begin
            wbOut.exc = ExcNone;
        end
        case (memIn.wbSel)
            WbMem:   wbOut.wbData = loadData;
            WbLink:  wbOut.wbData = memIn.pc + `DATA_WIDTH'(8);
            default: wbOut.wbData = memIn.aluOut;
        endcase
    end

    reqHeldUntilAck: assert property (@(posedge clk) disable iff (rst)
        memReq && !memAck |=> memReq);

    reqFieldsStable: assert property (@(posedge clk) disable iff (rst)
        memReq && $past(memReq) |-> $stable(memAddr) && $stable(memWe));

    noAdvanceDuringReq: assert property (@(posedge clk) disable iff (rst)
        memReq |-> !stageAdvance);

endmodule

// File: pipeStageReg.sv
`timescale 1ns/1ps

module pipeStageReg #(
    parameter type PayloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    input  logic    wr,
    input  PayloadT inData,
    output PayloadT outData
);

    logic [$bits(PayloadT)-1:0] outBits;

    // flush wins over wr and leaves a bubble
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            outData <= '0;
        end else if (wr) begin
            outData <= inData;
        end
    end

    assign outBits = outData;

    // the valid bit sits in the payload MSB
    validNoX: assert property (@(posedge clk) disable iff (rst)
        outBits[$bits(PayloadT)-1] |-> !$isunknown(outBits));

endmodule

// File: memBusPkg.sv
package memBusPkg;

    // one bit per byte lane of a data word
    typedef logic [3:0] ByteEnable;

    // byte offset within a word, taken from address bits 1:0
    typedef enum logic [1:0] {
        Lane0,
        Lane1,
        Lane2,
        Lane3
    } ByteLane;

    // single-lane enable for a byte access
    function automatic ByteEnable laneMask(input ByteLane lane);
        ByteEnable mask;
        mask = 4'b0001 << lane;
        return mask;
    endfunction

endpackage

// File: pipeTypesPkg.sv
`include "cpu_config.svh"

package pipeTypesPkg;

    // load kinds seen by the MEM stage
    typedef enum logic [2:0] {
        LdNone,
        LdLb,
        LdLbu,
        LdLh,
        LdLhu,
        LdLw
    } LoadType;

    // store kinds
    typedef enum logic [1:0] {
        StNone,
        StSb,
        StSh,
        StSw
    } StoreType;

    // writeback source
    typedef enum logic [1:0] {
        WbAlu,
        WbMem,
        WbLink
    } WbSelType;

    // exceptions raised in MEM
    typedef enum logic [1:0] {
        ExcNone,
        ExcLoadMisalign,
        ExcStoreMisalign
    } ExcCode;

    // valid stays the first field so it lands in the MSB of each payload
    typedef struct packed {
        logic                   valid;
        logic [`DATA_WIDTH-1:0] pc;
        logic [`DATA_WIDTH-1:0] aluOut;
        logic [`DATA_WIDTH-1:0] storeData;
        LoadType                loadType;
        StoreType               storeType;
        logic [4:0]             dst;
        logic                   regWrite;
        WbSelType               wbSel;
    } ExeMemPayload;

    typedef struct packed {
        logic                   valid;
        logic [`DATA_WIDTH-1:0] pc;
        logic [4:0]             dst;
        logic                   regWrite;
        logic [`DATA_WIDTH-1:0] wbData;
        ExcCode                 exc;
    } MemWbPayload;

endpackage

// File: cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath word width in bits
`define DATA_WIDTH 32

// data RAM depth in words
`define RAM_WORDS 256

// word-address width, log2 of RAM_WORDS
`define RAM_ADDR_W 8

// cycles between req rising and ack rising
`define ACK_DELAY 2

`endif
